// File: list.f
source/core_pkg.sv
source/fetch_unit.sv
source/reg_file.sv
source/decode_unit.sv
source/exec_unit.sv
source/mem_stage.sv
source/pipe_ctrl.sv
source/rv_core.sv
tb/tb_rv_core.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_rv_core -f list.f &&
./obj_dir/Vtb_rv_core ||
exit 1

// File: source/core_pkg.sv
package core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [31:0] inst_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [6:0]  funct7_t;

  localparam word_t RESET_PC = 32'h0000_0000;

  // Major opcodes
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_LOAD   = 7'b0000011;
  localparam opcode_t OPC_STORE  = 7'b0100011;
  localparam opcode_t OPC_BRANCH = 7'b1100011;

  localparam funct3_t F3_ADD_SUB = 3'b000;
  localparam funct3_t F3_SLT     = 3'b010;
  localparam funct3_t F3_XOR     = 3'b100;
  localparam funct3_t F3_OR      = 3'b110;
  localparam funct3_t F3_AND     = 3'b111;
  localparam funct3_t F3_WORD    = 3'b010;  // LW and SW only
  localparam funct3_t F3_BEQ     = 3'b000;
  localparam funct3_t F3_BNE     = 3'b001;

  localparam funct7_t F7_BASE = 7'b0000000;
  localparam funct7_t F7_SUB  = 7'b0100000;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  typedef struct packed {
    word_t     pc;
    alu_op_e   alu_op;
    word_t     op_a;
    word_t     op_b;
    word_t     store_data;
    reg_addr_t rd;
    logic      reg_write;
    logic      load;
    logic      store;
  } id_ex_t;

  typedef struct packed {
    reg_addr_t rd;
    logic      reg_write;
    logic      load;
    logic      store;
    word_t     alu_result;
    word_t     store_data;
  } ex_mem_t;

  typedef struct packed {
    reg_addr_t rd;
    logic      reg_write;
    logic      load;
    word_t     alu_result;
  } mem_wb_t;

  typedef struct packed {
    logic      write;
    logic      load;
    reg_addr_t rd;
    word_t     value;
  } fwd_t;

  typedef struct packed {
    logic      en;
    reg_addr_t addr;
    word_t     data;
  } wb_t;

  typedef struct packed {
    logic freeze;
    logic hold_front;
    logic bubble;
  } stall_t;

endpackage

// File: source/decode_unit.sv
`timescale 1ns/100ps

module decode_unit import core_pkg::*; (
  input  logic      clk,
  input  logic      rstn,
  input  stall_t    stall_i,
  input  word_t     pc_i,
  input  inst_t     inst_i,
  input  word_t     rdata1_i,
  input  word_t     rdata2_i,
  input  fwd_t      ex_fwd_i,
  input  fwd_t      mem_fwd_i,
  output reg_addr_t raddr1_o,
  output reg_addr_t raddr2_o,
  output logic      branch_taken_o,
  output word_t     branch_target_o,
  output logic      load_use_o,
  output id_ex_t    id_ex_o
);

  opcode_t   opcode;
  funct3_t   funct3;
  funct7_t   funct7;
  word_t     imm_i, imm_s, imm_b, imm_u;
  word_t     rs1_val, rs2_val;
  id_ex_t    dec;
  logic      legal, valid, use_rs1, use_rs2, is_branch, operands_eq;
  logic      squash;

  function automatic logic src_match(fwd_t f, reg_addr_t r);
    return f.write && f.rd == r && r != '0;
  endfunction

  // Youngest producer first
  function automatic word_t fwd_value(reg_addr_t r, word_t rf, fwd_t ex, fwd_t mem);
    if (src_match(ex, r)) return ex.value;
    if (src_match(mem, r)) return mem.value;
    return rf;
  endfunction

  function automatic logic load_hazard(reg_addr_t r, fwd_t ex, fwd_t mem);
    if (src_match(ex, r)) return ex.load;
    return src_match(mem, r) && mem.load;
  endfunction

  assign opcode   = inst_i[6:0];
  assign funct3   = inst_i[14:12];
  assign funct7   = inst_i[31:25];
  assign raddr1_o = inst_i[19:15];
  assign raddr2_o = inst_i[24:20];

  assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  assign imm_u = {inst_i[31:12], 12'b0};

  assign rs1_val = fwd_value(raddr1_o, rdata1_i, ex_fwd_i, mem_fwd_i);
  assign rs2_val = fwd_value(raddr2_o, rdata2_i, ex_fwd_i, mem_fwd_i);

  always_comb begin
    dec            = '0;
    dec.pc         = pc_i;
    dec.alu_op     = ALU_ADD;
    dec.op_a       = rs1_val;
    dec.op_b       = rs2_val;
    dec.store_data = rs2_val;
    dec.rd         = inst_i[11:7];
    legal          = 1'b1;
    use_rs1        = 1'b1;
    use_rs2        = 1'b0;
    is_branch      = 1'b0;
    case (opcode)
      OPC_OP: begin
        use_rs2       = 1'b1;
        dec.reg_write = 1'b1;
        case ({funct7, funct3})
          {F7_BASE, F3_ADD_SUB}: dec.alu_op = ALU_ADD;
          {F7_SUB, F3_ADD_SUB}:  dec.alu_op = ALU_SUB;
          {F7_BASE, F3_SLT}:     dec.alu_op = ALU_SLT;
          {F7_BASE, F3_XOR}:     dec.alu_op = ALU_XOR;
          {F7_BASE, F3_OR}:      dec.alu_op = ALU_OR;
          {F7_BASE, F3_AND}:     dec.alu_op = ALU_AND;
          default:               legal = 1'b0;
        endcase
      end
      OPC_OP_IMM: begin
        legal         = funct3 == F3_ADD_SUB;
        dec.op_b      = imm_i;
        dec.reg_write = 1'b1;
      end
      OPC_LUI: begin
        use_rs1       = 1'b0;
        dec.alu_op    = ALU_PASS_B;
        dec.op_b      = imm_u;
        dec.reg_write = 1'b1;
      end
      OPC_LOAD: begin
        legal         = funct3 == F3_WORD;
        dec.op_b      = imm_i;
        dec.reg_write = 1'b1;
        dec.load      = 1'b1;
      end
      OPC_STORE: begin
        legal     = funct3 == F3_WORD;
        use_rs2   = 1'b1;
        dec.op_b  = imm_s;
        dec.store = 1'b1;
      end
      OPC_BRANCH: begin
        use_rs2   = 1'b1;
        is_branch = funct3 == F3_BEQ || funct3 == F3_BNE;
        legal     = is_branch;
      end
      default: begin
        legal   = 1'b0;
        use_rs1 = 1'b0;
      end
    endcase
  end

  // Squashed slot also covers the stale word seen right after reset
  assign valid = legal && !squash;

  assign load_use_o = valid &&
                      ((use_rs1 && load_hazard(raddr1_o, ex_fwd_i, mem_fwd_i)) ||
                       (use_rs2 && load_hazard(raddr2_o, ex_fwd_i, mem_fwd_i)));

  assign operands_eq     = rs1_val == rs2_val;
  assign branch_target_o = pc_i + imm_b;
  assign branch_taken_o  = valid && is_branch && !load_use_o &&
                           ((funct3 == F3_BNE) ? !operands_eq : operands_eq);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      id_ex_o <= '0;
      squash  <= 1'b1;
    end else if (!stall_i.freeze) begin
      if (stall_i.bubble || !valid) begin
        id_ex_o <= '0;
      end else begin
        id_ex_o <= dec;
      end
      if (!stall_i.hold_front) begin
        squash <= branch_taken_o;
      end
    end
  end

  // Slot behind a taken branch is squashed and cannot branch again
  assert property (@(posedge clk) disable iff (!rstn)
    !(branch_taken_o && $past(branch_taken_o && !stall_i.freeze)))
    else $error("decode_unit: shadow slot of a taken branch branched at pc %h", pc_i);

endmodule

// File: source/exec_unit.sv
`timescale 1ns/100ps

module exec_unit import core_pkg::*; (
  input  logic    clk,
  input  logic    rstn,
  input  stall_t  stall_i,
  input  id_ex_t  id_ex_i,
  output fwd_t    ex_fwd_o,
  output ex_mem_t ex_mem_o
);

  word_t alu_result;

  always_comb begin
    case (id_ex_i.alu_op)
      ALU_ADD:    alu_result = id_ex_i.op_a + id_ex_i.op_b;
      ALU_SUB:    alu_result = id_ex_i.op_a - id_ex_i.op_b;
      ALU_AND:    alu_result = id_ex_i.op_a & id_ex_i.op_b;
      ALU_OR:     alu_result = id_ex_i.op_a | id_ex_i.op_b;
      ALU_XOR:    alu_result = id_ex_i.op_a ^ id_ex_i.op_b;
      // Signed compare
      ALU_SLT:    alu_result = {31'b0, $signed(id_ex_i.op_a) < $signed(id_ex_i.op_b)};
      ALU_PASS_B: alu_result = id_ex_i.op_b;
      default:    alu_result = id_ex_i.op_a + id_ex_i.op_b;
    endcase
  end

  // For a load the value here is only the address, decode stalls on it
  assign ex_fwd_o = '{
    write: id_ex_i.reg_write,
    load:  id_ex_i.load,
    rd:    id_ex_i.rd,
    value: alu_result
  };

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      ex_mem_o <= '0;
    end else if (!stall_i.freeze) begin
      ex_mem_o <= '{
        rd:         id_ex_i.rd,
        reg_write:  id_ex_i.reg_write,
        load:       id_ex_i.load,
        store:      id_ex_i.store,
        alu_result: alu_result,
        store_data: id_ex_i.store_data
      };
    end
  end

endmodule

// File: source/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit import core_pkg::*; (
  input  logic   clk,
  input  logic   rstn,
  input  stall_t stall_i,
  input  logic   branch_taken_i,
  input  word_t  branch_target_i,
  output logic   inst_read_o,
  output word_t  inst_addr_o,
  output word_t  id_pc_o
);

  word_t pc;
  word_t pc_next;
  logic  advance;

  // Front end moves unless frozen or held for a load-use
  assign advance = !stall_i.freeze && !stall_i.hold_front;
  assign pc_next = branch_taken_i ? branch_target_i : pc + 32'd4;

  // With no read the memory keeps presenting the held instruction
  assign inst_read_o = advance;
  assign inst_addr_o = pc;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      pc      <= RESET_PC;
      id_pc_o <= RESET_PC;
    end else if (advance) begin
      pc      <= pc_next;
      id_pc_o <= pc;
    end
  end

  // Branch targets from decode must keep the pc word aligned
  assert property (@(posedge clk) disable iff (!rstn) pc[1:0] == 2'b00)
    else $error("fetch_unit: misaligned pc %h", pc);

endmodule

// File: source/mem_stage.sv
`timescale 1ns/100ps

module mem_stage import core_pkg::*; (
  input  logic    clk,
  input  logic    rstn,
  input  stall_t  stall_i,
  input  ex_mem_t ex_mem_i,
  input  word_t   data_i,
  output logic    data_read_o,
  output logic    data_write_o,
  output word_t   data_addr_o,
  output word_t   data_wdata_o,
  output fwd_t    mem_fwd_o,
  output wb_t     wb_o
);

  mem_wb_t mem_wb;

  // No strobe while a cache stall is pending
  assign data_read_o  = ex_mem_i.load && !stall_i.freeze;
  assign data_write_o = ex_mem_i.store && !stall_i.freeze;
  assign data_addr_o  = ex_mem_i.alu_result;
  assign data_wdata_o = ex_mem_i.store_data;

  assign mem_fwd_o = '{
    write: ex_mem_i.reg_write,
    load:  ex_mem_i.load,
    rd:    ex_mem_i.rd,
    value: ex_mem_i.alu_result
  };

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      mem_wb <= '0;
    end else if (!stall_i.freeze) begin
      mem_wb <= '{
        rd:         ex_mem_i.rd,
        reg_write:  ex_mem_i.reg_write,
        load:       ex_mem_i.load,
        alu_result: ex_mem_i.alu_result
      };
    end
  end

  // Load data arrives one cycle after the read, i.e. in writeback
  assign wb_o = '{
    en:   mem_wb.reg_write && !stall_i.freeze,
    addr: mem_wb.rd,
    data: mem_wb.load ? data_i : mem_wb.alu_result
  };

  // Decode never marks one instruction as both load and store
  assert property (@(posedge clk) disable iff (!rstn) !(data_read_o && data_write_o))
    else $error("mem_stage: read and write strobes together at %h", data_addr_o);

endmodule

// File: source/pipe_ctrl.sv
`timescale 1ns/100ps

module pipe_ctrl import core_pkg::*; (
  input  logic   imem_stall_i,
  input  logic   dmem_stall_i,
  input  logic   load_use_i,
  output stall_t stall_o
);

  logic cache_stall;
  logic hazard_stall;

  assign cache_stall = imem_stall_i || dmem_stall_i;

  // A frozen pipe does not also insert a bubble
  assign hazard_stall = load_use_i && !cache_stall;

  // Every stage holds its register
  assign stall_o.freeze = cache_stall;

  // PC, fetched pc and the instruction word stay put
  assign stall_o.hold_front = hazard_stall;

  // ID/EX takes an empty slot while the load moves on
  assign stall_o.bubble = hazard_stall;

endmodule

// File: source/reg_file.sv
`timescale 1ns/100ps

module reg_file import core_pkg::*; (
  input  logic      clk,
  input  logic      rstn,
  input  wb_t       wb_i,
  input  reg_addr_t raddr1_i,
  input  reg_addr_t raddr2_i,
  output word_t     rdata1_o,
  output word_t     rdata2_o
);

  word_t regs [32];

  // x0 reads zero, a write in the same cycle wins over the array
  function automatic word_t read_port(reg_addr_t addr, wb_t wb, word_t stored);
    if (addr == '0) return '0;
    if (wb.en && wb.addr == addr) return wb.data;
    return stored;
  endfunction

  assign rdata1_o = read_port(raddr1_i, wb_i, regs[raddr1_i]);
  assign rdata2_o = read_port(raddr2_i, wb_i, regs[raddr2_i]);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_i.en && wb_i.addr != '0) begin
      regs[wb_i.addr] <= wb_i.data;
    end
  end

endmodule

// File: source/rv_core.sv
`timescale 1ns/100ps

module rv_core import core_pkg::*; (
  input  logic  clk,
  input  logic  rstn,
  // Instruction memory
  input  inst_t inst_i,
  output logic  inst_read_o,
  output word_t inst_addr_o,
  // Data memory
  input  word_t data_i,
  output logic  data_read_o,
  output logic  data_write_o,
  output word_t data_addr_o,
  output word_t data_wdata_o,
  // Cache stalls
  input  logic  imem_stall_i,
  input  logic  dmem_stall_i
);

  stall_t    stall;
  word_t     id_pc;
  logic      branch_taken;
  word_t     branch_target;
  logic      load_use;
  reg_addr_t raddr1, raddr2;
  word_t     rdata1, rdata2;
  fwd_t      ex_fwd, mem_fwd;
  id_ex_t    id_ex;
  ex_mem_t   ex_mem;
  wb_t       wb;

  pipe_ctrl i_pipe_ctrl (
    .imem_stall_i (imem_stall_i),
    .dmem_stall_i (dmem_stall_i),
    .load_use_i   (load_use),
    .stall_o      (stall)
  );

  fetch_unit i_fetch_unit (
    .clk             (clk),
    .rstn            (rstn),
    .stall_i         (stall),
    .branch_taken_i  (branch_taken),
    .branch_target_i (branch_target),
    .inst_read_o     (inst_read_o),
    .inst_addr_o     (inst_addr_o),
    .id_pc_o         (id_pc)
  );

  reg_file i_reg_file (
    .clk      (clk),
    .rstn     (rstn),
    .wb_i     (wb),
    .raddr1_i (raddr1),
    .raddr2_i (raddr2),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2)
  );

  decode_unit i_decode_unit (
    .clk             (clk),
    .rstn            (rstn),
    .stall_i         (stall),
    .pc_i            (id_pc),
    .inst_i          (inst_i),
    .rdata1_i        (rdata1),
    .rdata2_i        (rdata2),
    .ex_fwd_i        (ex_fwd),
    .mem_fwd_i       (mem_fwd),
    .raddr1_o        (raddr1),
    .raddr2_o        (raddr2),
    .branch_taken_o  (branch_taken),
    .branch_target_o (branch_target),
    .load_use_o      (load_use),
    .id_ex_o         (id_ex)
  );

  exec_unit i_exec_unit (
    .clk      (clk),
    .rstn     (rstn),
    .stall_i  (stall),
    .id_ex_i  (id_ex),
    .ex_fwd_o (ex_fwd),
    .ex_mem_o (ex_mem)
  );

  mem_stage i_mem_stage (
    .clk          (clk),
    .rstn         (rstn),
    .stall_i      (stall),
    .ex_mem_i     (ex_mem),
    .data_i       (data_i),
    .data_read_o  (data_read_o),
    .data_write_o (data_write_o),
    .data_addr_o  (data_addr_o),
    .data_wdata_o (data_wdata_o),
    .mem_fwd_o    (mem_fwd),
    .wb_o         (wb)
  );

endmodule

// File: tb/tb_rv_core.sv
`timescale 1ns/100ps

module tb_rv_core;

  localparam int PROG_LEN = 35;
  localparam int N_STORES = 10;
  localparam int TIMEOUT  = 20 * (PROG_LEN + N_STORES);

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
  } store_t;

  // Stores the program must produce, in order
  localparam store_t EXP_STORES [N_STORES] = '{
    '{32'h0000_0080, 32'h1234_5678},
    '{32'h0000_0084, 32'h0000_0778},
    '{32'h0000_0088, 32'hEDCB_A878},
    '{32'h0000_008C, 32'h0000_0001},
    '{32'h0000_0090, 32'h0000_0000},
    '{32'h0000_0094, 32'h0BAD_F01E},
    '{32'h0000_0098, 32'h1234_5678},
    '{32'h0000_009C, 32'h0000_0678},
    '{32'h0000_00A0, 32'h0000_0007},
    '{32'h0000_0100, 32'h1234_5000}
  };

  logic        clk, rstn;
  logic [31:0] inst_i, data_i;
  logic        inst_read_o, data_read_o, data_write_o;
  logic [31:0] inst_addr_o, data_addr_o, data_wdata_o;
  logic        imem_stall_i, dmem_stall_i;

  logic [31:0] prog [PROG_LEN];
  logic [31:0] imem [64];
  logic [31:0] dmem [128];

  // Memory requests as seen just before the edge
  logic        inst_req, data_rd_req, data_wr_req;
  logic [31:0] inst_req_addr, data_req_addr, data_req_wdata;

  logic        stalls_on;
  logic [31:0] lcg_state;
  logic [31:0] stall_rnd;
  int          cycles;
  int          store_count;

  rv_core i_rv_core (
    .clk          (clk),
    .rstn         (rstn),
    .inst_i       (inst_i),
    .inst_read_o  (inst_read_o),
    .inst_addr_o  (inst_addr_o),
    .data_i       (data_i),
    .data_read_o  (data_read_o),
    .data_write_o (data_write_o),
    .data_addr_o  (data_addr_o),
    .data_wdata_o (data_wdata_o),
    .imem_stall_i (imem_stall_i),
    .dmem_stall_i (dmem_stall_i)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] alu_inst(int f7, int f3, int rd, int rs1, int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] addi_inst(int rd, int rs1, int imm);
    return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
  endfunction

  function automatic logic [31:0] lw_inst(int rd, int rs1, int imm);
    return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
  endfunction

  function automatic logic [31:0] sw_inst(int rs2, int rs1, int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] branch_inst(int f3, int rs1, int rs2, int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] lui_inst(int rd, int imm);
    return {imm[19:0], rd[4:0], 7'b0110111};
  endfunction

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic build_program();
    prog[0]  = lui_inst(1, 'h12345);
    prog[1]  = addi_inst(2, 0, 'h678);
    prog[2]  = addi_inst(3, 0, -256);
    prog[3]  = alu_inst(0, 0, 4, 1, 2);
    prog[4]  = sw_inst(4, 0, 'h80);
    prog[5]  = alu_inst('h20, 0, 5, 2, 3);
    prog[6]  = sw_inst(5, 0, 'h84);
    // and, or, xor chained back to back
    prog[7]  = alu_inst(0, 7, 6, 4, 3);
    prog[8]  = alu_inst(0, 6, 7, 6, 5);
    prog[9]  = alu_inst(0, 4, 8, 7, 3);
    prog[10] = sw_inst(8, 0, 'h88);
    prog[11] = alu_inst(0, 2, 9, 3, 2);
    prog[12] = alu_inst(0, 2, 10, 2, 3);
    prog[13] = sw_inst(9, 0, 'h8C);
    prog[14] = sw_inst(10, 0, 'h90);
    // Load then immediate use
    prog[15] = lw_inst(12, 0, 'h40);
    prog[16] = addi_inst(13, 12, 'h11);
    prog[17] = sw_inst(13, 0, 'h94);
    prog[18] = lw_inst(14, 0, 'h80);
    prog[19] = sw_inst(14, 0, 'h98);
    prog[20] = branch_inst(0, 4, 1, 8);
    prog[21] = sw_inst(2, 0, 'h9C);
    prog[22] = branch_inst(1, 4, 1, 8);
    prog[23] = sw_inst(3, 0, 'h1F0);
    prog[24] = addi_inst(15, 0, 7);
    prog[25] = branch_inst(1, 15, 0, 12);
    prog[26] = sw_inst(15, 0, 'h1F4);
    prog[27] = sw_inst(15, 0, 'h1F8);
    // Branch waits on a load
    prog[28] = lw_inst(16, 0, 'h40);
    prog[29] = branch_inst(0, 16, 12, 8);
    prog[30] = sw_inst(0, 0, 'h1FC);
    prog[31] = branch_inst(1, 16, 12, 8);
    prog[32] = sw_inst(15, 0, 'hA0);
    prog[33] = sw_inst(1, 0, 'h100);
    prog[34] = branch_inst(0, 0, 0, 0);
  endtask

  task automatic init_memories();
    for (int i = 0; i < 64; i++) begin
      if (i < PROG_LEN) begin
        imem[i] = prog[i];
      end else begin
        imem[i] = {i[24:0], 7'h7f};
      end
    end
    for (int i = 0; i < 128; i++) begin
      dmem[i] = 32'hD000_0000 | (i << 2);
    end
    dmem[16] = 32'h0BAD_F00D;
  endtask

  always @(negedge clk) begin
    inst_req       = inst_read_o;
    inst_req_addr  = inst_addr_o;
    data_rd_req    = data_read_o;
    data_wr_req    = data_write_o;
    data_req_addr  = data_addr_o;
    data_req_wdata = data_wdata_o;
  end

  // Memories answer and stalls change shortly after the edge
  always @(posedge clk) begin
    #1;
    if (inst_req) begin
      inst_i = imem[inst_req_addr[7:2]];
    end
    if (data_rd_req) begin
      data_i = dmem[data_req_addr[8:2]];
    end
    if (data_wr_req) begin
      dmem[data_req_addr[8:2]] = data_req_wdata;
    end
    stall_rnd    = lcg_next();
    imem_stall_i = stalls_on && (stall_rnd[23:16] < 8'd51);
    stall_rnd    = lcg_next();
    dmem_stall_i = stalls_on && (stall_rnd[23:16] < 8'd51);
  end

  always @(negedge clk) begin
    if (!rstn) begin
      store_count <= 0;
    end else begin
      if (data_write_o) begin
        store_count <= store_count + 1;
      end
      assert (!((imem_stall_i || dmem_stall_i) &&
                (inst_read_o || data_read_o || data_write_o)))
        else fail_run("a memory strobe was high while a cache stall was raised");
    end
  end

  always @(posedge clk) begin
    if (!rstn) begin
      cycles <= 0;
    end else begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT) begin
        fail_run("timeout while waiting for the store sequence");
      end
    end
  end

  task automatic reset_core();
    @(posedge clk);
    #1;
    stalls_on = 1'b0;
    rstn      = 1'b0;
    init_memories();
    repeat (5) @(posedge clk);
    #1;
    rstn = 1'b1;
    @(negedge clk);
    assert (inst_addr_o == 32'h0)
      else fail_run($sformatf("error: inst_addr_o is %h, expected %h", inst_addr_o, 32'h0));
    assert (inst_read_o)
      else fail_run("no instruction fetch in the first cycle after reset");
    assert (!data_read_o && !data_write_o)
      else fail_run("a data strobe was high in the first cycle after reset");
  endtask

  task automatic run_phase(input logic with_stalls);
    reset_core();
    stalls_on = with_stalls;
    for (int i = 0; i < N_STORES; i++) begin
      do @(negedge clk); while (!data_write_o);
      assert (data_addr_o == EXP_STORES[i].addr)
        else fail_run($sformatf("error: data_addr_o is %h, expected %h",
                                data_addr_o, EXP_STORES[i].addr));
      assert (data_wdata_o == EXP_STORES[i].data)
        else fail_run($sformatf("error: data_wdata_o is %h, expected %h",
                                data_wdata_o, EXP_STORES[i].data));
    end
    // Program spins after the last store
    repeat (20) @(negedge clk);
    @(posedge clk);
    assert (store_count == N_STORES)
      else fail_run($sformatf("error: data_write_o count is %h, expected %h",
                              store_count, N_STORES));
  endtask

  initial begin
    clk            = 1'b0;
    rstn           = 1'b0;
    inst_i         = 32'h0000_0013;
    data_i         = 32'h0;
    imem_stall_i   = 1'b0;
    dmem_stall_i   = 1'b0;
    stalls_on      = 1'b0;
    lcg_state      = 32'd82505;
    inst_req       = 1'b0;
    data_rd_req    = 1'b0;
    data_wr_req    = 1'b0;
    inst_req_addr  = 32'h0;
    data_req_addr  = 32'h0;
    data_req_wdata = 32'h0;
    build_program();
    // Clean run, then the same program under random cache stalls
    run_phase(1'b0);
    run_phase(1'b1);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule
